//--- usbPe.f
src/usbPePkg.sv
src/usbPeTokenDecoder.sv
src/usbPeEpFifo.sv
src/usbPeCtrl.sv
src/usbPeTxFramer.sv
src/usbPe.sv
verif/usbPeTb.sv

//--- run.sh
#!/bin/sh
# Build the USB protocol engine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module usbPeTb -f usbPe.f -o usbPeSim

out=$(./obj_dir/usbPeSim)
echo "$out"

# The pass line decides the exit status
echo "$out" | grep -qx "No errors"

//--- verif/usbPeTb.sv
`timescale 1ns/10ps
`default_nettype none

module usbPeTb;

    import usbPePkg::*;

    localparam int numEp     = 4;
    localparam int fifoDepth = 16;
    localparam int maxPacket = 8;
    localparam devAddrT devAddr = 7'h2A;
    // Some 20 transactions of at most 30 cycles each, plus pops, with a wide margin
    localparam int cycleLimit = 20000;

    logic             clk48;
    logic             rstN;
    rxBeatT           rxBeat;
    logic             rxValid;
    logic             rxReady;
    txBeatT           txBeat;
    logic             txValid;
    logic             txReady;
    logic [numEp-1:0] epOutPop;
    byteT             epOutData [numEp];
    logic [numEp-1:0] epOutAvail;
    logic [numEp-1:0] epInPush;
    byteT             epInData [numEp];
    logic [numEp-1:0] epInCommit;
    logic [numEp-1:0] epInRollback;
    logic [numEp-1:0] epInFull;

    int          errCount = 0;
    int          cycles = 0;
    logic [31:0] rngState;
    // Endpoint contents as {ep, byte}, host to device and device to host
    logic [11:0] outModel [$];
    logic [11:0] inModel [$];
    // Expected tx beats as {data, isLast} with the test that queued them
    logic [8:0]  expQ [$];
    string       expName [$];
    // Payload of the next OUT data packet
    byteT        payload [$];

    usbPe #(.numEp(numEp), .fifoDepth(fifoDepth), .maxPacket(maxPacket)) uut (
        .clk48_i        (clk48),
        .rstN_i         (rstN),
        .devAddr_i      (devAddr),
        .rx_i           (rxBeat),
        .rxValid_i      (rxValid),
        .rxReady_o      (rxReady),
        .tx_o           (txBeat),
        .txValid_o      (txValid),
        .txReady_i      (txReady),
        .epOutPop_i     (epOutPop),
        .epOutData_o    (epOutData),
        .epOutAvail_o   (epOutAvail),
        .epInPush_i     (epInPush),
        .epInData_i     (epInData),
        .epInCommit_i   (epInCommit),
        .epInRollback_i (epInRollback),
        .epInFull_o     (epInFull)
    );

    // ============================================================
    // Clock, timeout and random back-pressure
    // ============================================================

    initial begin
        clk48 = 1'b0;
        forever #50 clk48 = ~clk48;
    end

    always @(posedge clk48) cycles <= cycles + 1;

    initial begin
        while (cycles < cycleLimit) @(posedge clk48);
        $display("Timeout after %0d cycles, %0d responses still pending", cycles, expQ.size());
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Frontend ready about three cycles in four
    initial begin
        txReady  = 1'b0;
        rngState = 32'h7818_63f3;
        forever begin
            @(posedge clk48);
            #5;
            rngState = xorshift(rngState);
            txReady  = |rngState[1:0];
        end
    end

    // ============================================================
    // Reference model
    // ============================================================

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errCount++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic int countEp(input logic [11:0] q [$], input int ep);
        int n;
        n = 0;
        foreach (q[i]) begin
            if (int'(q[i][11:8]) == ep) n++;
        end
        return n;
    endfunction

    // Index of the oldest byte held for an endpoint, -1 if none
    function automatic int firstEp(input logic [11:0] q [$], input int ep);
        int idx;
        idx = -1;
        for (int i = q.size() - 1; i >= 0; i--) begin
            if (int'(q[i][11:8]) == ep) idx = i;
        end
        return idx;
    endfunction

    function automatic void expectBeat(input string name, input byteT data, input logic isLast);
        expQ.push_back({data, isLast});
        expName.push_back(name);
    endfunction

    // Handshake and data PIDs go out with their check nibble
    function automatic byteT pidByte(input pidT pid);
        return {~pid, pid};
    endfunction

    // Expected response of one transaction addressed to this device
    function automatic void predict(input string name, input logic isIn, input int ep,
                                    input logic keep);
        int n;
        int idx;
        n = 0;
        if (ep >= numEp) begin
            // A CRC error on the data packet silences even a STALL
            if (isIn || keep) expectBeat(name, pidByte(PID_STALL), 1'b1);
        end else if (isIn) begin
            n = countEp(inModel, ep);
            if (n == 0) begin
                expectBeat(name, pidByte(PID_NAK), 1'b1);
            end else begin
                expectBeat(name, pidByte(PID_DATA0), 1'b0);
                if (n > maxPacket) n = maxPacket;
                for (int i = 0; i < n; i++) begin
                    idx = firstEp(inModel, ep);
                    expectBeat(name, inModel[idx][7:0], i == n - 1);
                    inModel.delete(idx);
                end
            end
        end else if (keep) begin
            // Free space counts every stored byte not yet popped
            if (countEp(outModel, ep) + payload.size() > fifoDepth) begin
                expectBeat(name, pidByte(PID_NAK), 1'b1);
            end else begin
                foreach (payload[i]) outModel.push_back({4'(ep), payload[i]});
                expectBeat(name, pidByte(PID_ACK), 1'b1);
            end
        end
    endfunction

    // Every tx transfer is compared, sampled mid-cycle where it is stable
    always @(negedge clk48) begin
        if (rstN && txValid && txReady) begin
            if (expQ.size() == 0) begin
                errCount++;
                $display("Unexpected tx byte %h sent with no response pending", txBeat.data);
            end else begin
                check(expName.pop_front(), expQ.pop_front(), txBeat);
            end
        end
    end

    // ============================================================
    // Stimulus tasks
    // ============================================================

    // Byte moves on the first edge where the engine is ready
    task automatic sendByte(input byteT data, input logic isLast, input logic keep);
        rxBeat.data   = data;
        rxBeat.isLast = isLast;
        rxBeat.keep   = keep;
        rxValid       = 1'b1;
        @(negedge clk48);
        while (!rxReady) @(negedge clk48);
        @(posedge clk48);
        #5;
    endtask

    task automatic sendToken(input pidT pid, input devAddrT addr, input epNumT ep,
                             input logic badCheck);
        sendByte(badCheck ? {pid, pid} : pidByte(pid), 1'b0, 1'b1);
        sendByte({ep[0], addr}, 1'b0, 1'b1);
        sendByte({5'd0, ep[3:1]}, 1'b1, 1'b1);
        rxValid = 1'b0;
    endtask

    // DATA1 is accepted as well, toggle is not tracked
    task automatic sendData(input logic keep, input logic useData1);
        sendByte(pidByte(useData1 ? PID_DATA1 : PID_DATA0), 1'b0, 1'b1);
        foreach (payload[i]) begin
            sendByte(payload[i], i == payload.size() - 1, (i == payload.size() - 1) ? keep : 1'b1);
        end
        rxValid = 1'b0;
    endtask

    task automatic fillPayload(input int n, input byteT base);
        payload.delete();
        for (int i = 0; i < n; i++) payload.push_back(8'(base + i * 37));
    endtask

    // Response sent and engine back to waiting for a token
    task automatic waitIdle();
        while (expQ.size() != 0) @(posedge clk48);
        @(negedge clk48);
        while (!rxReady) @(negedge clk48);
        @(posedge clk48);
        #5;
    endtask

    task automatic popOut(input string name, input int ep, input int n);
        int idx;
        for (int i = 0; i < n; i++) begin
            idx = firstEp(outModel, ep);
            check(name, 1, epOutAvail[ep]);
            if (idx < 0) begin
                errCount++;
                $display("Model holds no byte for endpoint %0d in %s", ep, name);
            end else begin
                check(name, outModel[idx][7:0], epOutData[ep]);
                outModel.delete(idx);
            end
            if (epOutAvail[ep]) begin
                epOutPop[ep] = 1'b1;
                @(posedge clk48);
                #5;
                epOutPop[ep] = 1'b0;
            end
        end
    endtask

    task automatic pushIn(input int ep, input int n, input logic commit, input byteT base);
        int held;
        held = countEp(inModel, ep) + n;
        for (int i = 0; i < n; i++) begin
            epInData[ep] = 8'(base + i * 11);
            epInPush[ep] = 1'b1;
            if (commit) inModel.push_back({4'(ep), epInData[ep]});
            @(posedge clk48);
            #5;
        end
        // Uncommitted bytes already take room
        check("inFifoFull", held >= fifoDepth, epInFull[ep]);
        epInPush[ep]     = 1'b0;
        epInCommit[ep]   = commit;
        epInRollback[ep] = !commit;
        @(posedge clk48);
        #5;
        epInCommit[ep]   = 1'b0;
        epInRollback[ep] = 1'b0;
        check("inFifoFullAfterEnd", countEp(inModel, ep) >= fifoDepth, epInFull[ep]);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        rstN         = 1'b0;
        rxBeat       = '0;
        rxValid      = 1'b0;
        epOutPop     = '0;
        epInPush     = '0;
        epInCommit   = '0;
        epInRollback = '0;
        for (int i = 0; i < numEp; i++) epInData[i] = '0;
        repeat (16) @(posedge clk48);
        #5;
        rstN = 1'b1;
        check("resetReady", 1, rxReady);
        check("resetTxIdle", 0, txValid);
        check("resetEmpty", 0, epOutAvail);

        // OUT accepted and read back in order
        fillPayload(5, 8'h10);
        predict("outAck", 1'b0, 1, 1'b1);
        sendToken(PID_OUT, devAddr, 4'd1, 1'b0);
        sendData(1'b1, 1'b0);
        waitIdle();
        popOut("outAckPop", 1, 5);
        check("outAckDrained", 0, epOutAvail[1]);

        // Second packet does not fit next to the first
        fillPayload(12, 8'h40);
        predict("outFill", 1'b0, 2, 1'b1);
        sendToken(PID_OUT, devAddr, 4'd2, 1'b0);
        sendData(1'b1, 1'b1);
        waitIdle();
        fillPayload(6, 8'h80);
        predict("outNak", 1'b0, 2, 1'b1);
        sendToken(PID_OUT, devAddr, 4'd2, 1'b0);
        sendData(1'b1, 1'b0);
        waitIdle();
        popOut("outNakPop", 2, 12);
        check("outNakNoExtra", 0, epOutAvail[2]);

        // CRC error stays silent, the following NAK comes first
        fillPayload(4, 8'hA0);
        predict("outCrcErr", 1'b0, 3, 1'b0);
        sendToken(PID_OUT, devAddr, 4'd3, 1'b0);
        sendData(1'b0, 1'b0);
        waitIdle();
        check("outCrcErrEmpty", 0, epOutAvail[3]);
        predict("inEmpty", 1'b1, 3, 1'b1);
        sendToken(PID_IN, devAddr, 4'd3, 1'b0);
        waitIdle();

        // IN split into a full packet and a short one
        pushIn(0, 11, 1'b1, 8'h21);
        predict("inFull", 1'b1, 0, 1'b1);
        sendToken(PID_IN, devAddr, 4'd0, 1'b0);
        waitIdle();
        predict("inShort", 1'b1, 0, 1'b1);
        sendToken(PID_IN, devAddr, 4'd0, 1'b0);
        waitIdle();
        predict("inDrained", 1'b1, 0, 1'b1);
        sendToken(PID_IN, devAddr, 4'd0, 1'b0);
        waitIdle();
        // A whole FIFO of uncommitted bytes, then thrown away
        pushIn(1, 16, 1'b0, 8'h66);
        predict("inRolledBack", 1'b1, 1, 1'b1);
        sendToken(PID_IN, devAddr, 4'd1, 1'b0);
        waitIdle();

        // Endpoint 5 does not exist
        fillPayload(3, 8'h33);
        predict("outStall", 1'b0, 5, 1'b1);
        sendToken(PID_OUT, devAddr, 4'd5, 1'b0);
        sendData(1'b1, 1'b0);
        waitIdle();
        predict("inStall", 1'b1, 5, 1'b1);
        sendToken(PID_IN, devAddr, 4'd5, 1'b0);
        waitIdle();

        // Foreign address and broken PID, no response expected
        fillPayload(4, 8'h55);
        sendToken(PID_OUT, 7'h15, 4'd1, 1'b0);
        sendData(1'b1, 1'b0);
        waitIdle();
        sendToken(PID_OUT, devAddr, 4'd1, 1'b1);
        sendData(1'b1, 1'b0);
        waitIdle();
        check("ignoredOutEmpty", 0, epOutAvail[1]);
        pushIn(0, 2, 1'b1, 8'hC7);
        sendToken(PID_IN, 7'h2B, 4'd0, 1'b0);
        waitIdle();
        sendToken(PID_IN, devAddr, 4'd0, 1'b1);
        waitIdle();
        predict("inAfterIgnored", 1'b1, 0, 1'b1);
        sendToken(PID_IN, devAddr, 4'd0, 1'b0);
        waitIdle();

        if (expQ.size() != 0) begin
            errCount++;
            $display("%0d expected response bytes were never sent", expQ.size());
        end
        $display("Finished after %0d cycles with %0d mismatches or failures", cycles, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/usbPe.sv
`timescale 1ns/10ps
`default_nettype none

module usbPe #(
    parameter int numEp     = 4,
    parameter int fifoDepth = 16,
    parameter int maxPacket = 8
) (
    input  logic              clk48_i,
    input  logic              rstN_i,
    input  usbPePkg::devAddrT devAddr_i,
    input  usbPePkg::rxBeatT  rx_i,
    input  logic              rxValid_i,
    output logic              rxReady_o,
    output usbPePkg::txBeatT  tx_o,
    output logic              txValid_o,
    input  logic              txReady_i,
    input  logic [numEp-1:0]  epOutPop_i,
    output usbPePkg::byteT    epOutData_o [numEp],
    output logic [numEp-1:0]  epOutAvail_o,
    input  logic [numEp-1:0]  epInPush_i,
    input  usbPePkg::byteT    epInData_i [numEp],
    input  logic [numEp-1:0]  epInCommit_i,
    input  logic [numEp-1:0]  epInRollback_i,
    output logic [numEp-1:0]  epInFull_o
);

    import usbPePkg::*;

    localparam int cntW = $clog2(fifoDepth) + 1;

    tokenT            token;
    logic             tokenStrobe;
    logic             tokenPhase;
    epNumT            epSel;
    logic             outWr;
    logic             outCommit;
    logic             outRollback;
    logic             outFull;
    logic [cntW-1:0]  inCount;
    byteT             inHead;
    logic             inPop;
    pidT              sendPid;
    logic             sendStart;
    logic             sendDone;
    // One-hot endpoint select, all zero when out of range
    logic [numEp-1:0] epHit;
    logic [numEp-1:0] outFullArr;
    logic [cntW-1:0]  outCountArr [numEp];
    logic [cntW-1:0]  inCountArr [numEp];
    byteT             inHeadArr [numEp];

    // ============================================================
    // Token, control and transmit
    // ============================================================

    usbPeTokenDecoder tokenDec (
        .clk48_i       (clk48_i),
        .rstN_i        (rstN_i),
        .devAddr_i     (devAddr_i),
        .rxByte_i      (rx_i),
        .byteStrobe_i  (tokenPhase),
        .token_o       (token),
        .tokenStrobe_o (tokenStrobe)
    );

    usbPeCtrl #(.numEp(numEp), .fifoDepth(fifoDepth)) ctrl (
        .clk48_i       (clk48_i),
        .rstN_i        (rstN_i),
        .rx_i          (rx_i),
        .rxValid_i     (rxValid_i),
        .rxReady_o     (rxReady_o),
        .tokenPhase_o  (tokenPhase),
        .token_i       (token),
        .tokenStrobe_i (tokenStrobe),
        .epSel_o       (epSel),
        .outWr_o       (outWr),
        .outCommit_o   (outCommit),
        .outRollback_o (outRollback),
        .outFull_i     (outFull),
        .inCount_i     (inCount),
        .sendPid_o     (sendPid),
        .sendStart_o   (sendStart),
        .sendDone_i    (sendDone)
    );

    usbPeTxFramer #(.fifoDepth(fifoDepth), .maxPacket(maxPacket)) framer (
        .clk48_i     (clk48_i),
        .rstN_i      (rstN_i),
        .sendPid_i   (sendPid),
        .sendStart_i (sendStart),
        .sendDone_o  (sendDone),
        .inCount_i   (inCount),
        .inData_i    (inHead),
        .inPop_o     (inPop),
        .tx_o        (tx_o),
        .txValid_o   (txValid_o),
        .txReady_i   (txReady_i)
    );

    // ============================================================
    // Endpoint select and FIFO arrays
    // ============================================================

    assign epHit = numEp'(1) << epSel;

    // Selected endpoint status back to control and framer
    always_comb begin
        outFull = 1'b0;
        inCount = '0;
        inHead  = '0;
        for (int i = 0; i < numEp; i++) begin
            if (epHit[i]) begin
                outFull = outFullArr[i];
                inCount = inCountArr[i];
                inHead  = inHeadArr[i];
            end
        end
    end

    // Host to device, engine writes and user pops
    for (genvar i = 0; i < numEp; i++) begin : genOutFifo
        usbPeEpFifo #(.depth(fifoDepth)) outFifo (
            .clk48_i          (clk48_i),
            .rstN_i           (rstN_i),
            .wrData_i         (rx_i.data),
            .wr_i             (outWr && epHit[i]),
            .commit_i         (outCommit && epHit[i]),
            .rollback_i       (outRollback && epHit[i]),
            .pop_i            (epOutPop_i[i]),
            .rdData_o         (epOutData_o[i]),
            .committedCount_o (outCountArr[i]),
            .full_o           (outFullArr[i])
        );
        assign epOutAvail_o[i] = outCountArr[i] != '0;
    end

    // Device to host, user writes and engine pops
    for (genvar i = 0; i < numEp; i++) begin : genInFifo
        usbPeEpFifo #(.depth(fifoDepth)) inFifo (
            .clk48_i          (clk48_i),
            .rstN_i           (rstN_i),
            .wrData_i         (epInData_i[i]),
            .wr_i             (epInPush_i[i]),
            .commit_i         (epInCommit_i[i]),
            .rollback_i       (epInRollback_i[i]),
            .pop_i            (inPop && epHit[i]),
            .rdData_o         (inHeadArr[i]),
            .committedCount_o (inCountArr[i]),
            .full_o           (epInFull_o[i])
        );
    end

endmodule

`default_nettype wire

//--- src/usbPeTxFramer.sv
`timescale 1ns/10ps
`default_nettype none

module usbPeTxFramer #(
    parameter int fifoDepth = 16,
    parameter int maxPacket = 8
) (
    input  logic                       clk48_i,
    input  logic                       rstN_i,
    input  usbPePkg::pidT              sendPid_i,
    input  logic                       sendStart_i,
    output logic                       sendDone_o,
    input  logic [$clog2(fifoDepth):0] inCount_i,
    input  usbPePkg::byteT             inData_i,
    output logic                       inPop_o,
    output usbPePkg::txBeatT           tx_o,
    output logic                       txValid_o,
    input  logic                       txReady_i
);

    import usbPePkg::*;

    localparam int sentW = $clog2(maxPacket + 1);

    logic             txFire;
    // Payload bytes loaded so far
    logic [sentW-1:0] sentCnt;
    logic             lastLoad;

    assign txFire     = txValid_o && txReady_i;
    assign sendDone_o = txFire && tx_o.isLast;
    // Every accepted beat that is not the last pulls the next byte
    assign inPop_o    = txFire && !tx_o.isLast;
    // Stop at packet size or at the last committed byte
    assign lastLoad   = (int'(sentCnt) == maxPacket - 1) || (inCount_i == 'd1);

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            txValid_o <= 1'b0;
            sentCnt   <= '0;
        end else if (sendStart_i) begin
            txValid_o <= 1'b1;
            sentCnt   <= '0;
        end else if (sendDone_o) begin
            txValid_o <= 1'b0;
        end else if (inPop_o) begin
            sentCnt <= sentCnt + 1'b1;
        end
    end

    // Output beat only moves on a transfer, so back-pressure holds it
    always_ff @(posedge clk48_i) begin
        if (sendStart_i) begin
            tx_o.data   <= {~sendPid_i, sendPid_i};
            tx_o.isLast <= sendPid_i != PID_DATA0;
        end else if (inPop_o) begin
            tx_o.data   <= inData_i;
            tx_o.isLast <= lastLoad;
        end
    end

    aHoldBeat : assert property (
        @(posedge clk48_i) disable iff (!rstN_i)
        txValid_o && !txReady_i |=> txValid_o && $stable(tx_o)
    ) else $error("Tx beat changed under back-pressure");

endmodule

`default_nettype wire

//--- src/usbPeCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module usbPeCtrl #(
    parameter int numEp     = 4,
    parameter int fifoDepth = 16
) (
    input  logic                       clk48_i,
    input  logic                       rstN_i,
    input  usbPePkg::rxBeatT           rx_i,
    input  logic                       rxValid_i,
    output logic                       rxReady_o,
    output logic                       tokenPhase_o,
    input  usbPePkg::tokenT            token_i,
    input  logic                       tokenStrobe_i,
    output usbPePkg::epNumT            epSel_o,
    output logic                       outWr_o,
    output logic                       outCommit_o,
    output logic                       outRollback_o,
    input  logic                       outFull_i,
    input  logic [$clog2(fifoDepth):0] inCount_i,
    output usbPePkg::pidT              sendPid_o,
    output logic                       sendStart_o,
    input  logic                       sendDone_i
);

    import usbPePkg::*;

    peStateT state;
    logic    rxFire;
    logic    tokenInRange;
    // Next rx byte is the data packet PID
    logic    pidPending;
    // OUT for us with a valid endpoint
    logic    wrEnable;
    logic    refused;
    logic    refusedNow;
    logic    acceptNow;
    logic    respSend;
    pidT     respPid;
    logic    doCommit;
    logic    doRollback;

    // ============================================================
    // Stream side
    // ============================================================

    // Receive only while waiting, so one transaction at a time
    assign rxReady_o    = (state == waitToken) || (state == rxData);
    assign rxFire       = rxValid_i && rxReady_o;
    assign tokenPhase_o = rxFire && (state == waitToken);
    assign tokenInRange = int'(token_i.ep) < numEp;

    assign outWr_o    = rxFire && (state == rxData) && wrEnable && !pidPending;
    // Byte lost now or earlier in this packet
    assign refusedNow = refused || (outWr_o && outFull_i);
    // Packet is kept only with a good CRC and no lost byte
    assign acceptNow  = rx_i.keep && !refusedNow;

    // Commit or rollback lands one cycle after the last byte
    assign outCommit_o   = (state == respond) && doCommit;
    assign outRollback_o = (state == respond) && doRollback;
    assign sendStart_o   = (state == respond) && respSend;

    // IN data is decided once the endpoint select has settled
    assign sendPid_o = (respPid == PID_DATA0 && inCount_i == '0) ? PID_NAK : respPid;

    // ============================================================
    // Transaction FSM
    // ============================================================

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            state      <= waitToken;
            epSel_o    <= '0;
            pidPending <= 1'b0;
            wrEnable   <= 1'b0;
            refused    <= 1'b0;
            respSend   <= 1'b0;
            respPid    <= PID_NAK;
            doCommit   <= 1'b0;
            doRollback <= 1'b0;
        end else begin
            case (state)
                waitToken: begin
                    if (tokenStrobe_i) begin
                        epSel_o    <= token_i.ep;
                        pidPending <= 1'b1;
                        refused    <= 1'b0;
                        doCommit   <= 1'b0;
                        doRollback <= 1'b0;
                        wrEnable   <= token_i.forMe && tokenInRange;
                        respPid    <= tokenInRange ? PID_DATA0 : PID_STALL;
                        // Data after a foreign OUT is still swallowed here
                        if (token_i.pid == PID_OUT) begin
                            respSend <= token_i.forMe;
                            state    <= rxData;
                        end else if (token_i.forMe && token_i.pid == PID_IN) begin
                            respSend <= 1'b1;
                            state    <= respond;
                        end
                    end
                end
                rxData: begin
                    if (rxFire) begin
                        pidPending <= 1'b0;
                        refused    <= refusedNow;
                        if (rx_i.isLast) begin
                            // CRC error means silence
                            respSend   <= respSend && rx_i.keep;
                            doCommit   <= wrEnable && acceptNow;
                            doRollback <= wrEnable && !acceptNow;
                            if (!wrEnable) begin
                                respPid <= PID_STALL;
                            end else begin
                                respPid <= refusedNow ? PID_NAK : PID_ACK;
                            end
                            state <= respond;
                        end
                    end
                end
                respond: begin
                    state <= respSend ? txData : waitToken;
                end
                txData: begin
                    if (sendDone_i) begin
                        state <= waitToken;
                    end
                end
                default: begin
                    state <= waitToken;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/usbPeEpFifo.sv
`timescale 1ns/10ps
`default_nettype none

module usbPeEpFifo #(
    parameter int depth = 16
) (
    input  logic                   clk48_i,
    input  logic                   rstN_i,
    input  usbPePkg::byteT         wrData_i,
    input  logic                   wr_i,
    input  logic                   commit_i,
    input  logic                   rollback_i,
    input  logic                   pop_i,
    output usbPePkg::byteT         rdData_o,
    output logic [$clog2(depth):0] committedCount_o,
    output logic                   full_o
);

    import usbPePkg::*;

    localparam int addrW = $clog2(depth);

    // Pointers carry one extra bit to tell full from empty
    typedef logic [addrW:0] ptrT;

    byteT mem [depth];
    ptrT  rdPtr;
    ptrT  wrPtr;
    ptrT  cmtPtr;
    ptrT  wrNext;
    logic wrFire;
    logic overflow;

    // ============================================================
    // Status and storage
    // ============================================================

    // Full counts uncommitted bytes too
    assign full_o = (wrPtr - rdPtr) == ptrT'(depth);
    assign wrFire = wr_i && !full_o;
    assign wrNext = wrPtr + ptrT'(wrFire);

    // Reader only sees bytes up to the committed pointer
    assign committedCount_o = cmtPtr - rdPtr;
    assign rdData_o         = mem[rdPtr[addrW-1:0]];

    always_ff @(posedge clk48_i) begin
        if (wrFire) begin
            mem[wrPtr[addrW-1:0]] <= wrData_i;
        end
    end

    // ============================================================
    // Pointer update
    // ============================================================

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            rdPtr    <= '0;
            wrPtr    <= '0;
            cmtPtr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (pop_i) begin
                rdPtr <= rdPtr + ptrT'(1);
            end
            // A packet that lost a byte is never made visible
            if (rollback_i || (commit_i && overflow)) begin
                wrPtr    <= cmtPtr;
                overflow <= 1'b0;
            end else if (commit_i) begin
                wrPtr    <= wrNext;
                cmtPtr   <= wrNext;
                overflow <= 1'b0;
            end else begin
                wrPtr <= wrNext;
                if (wr_i && full_o) begin
                    overflow <= 1'b1;
                end
            end
        end
    end

    aCommitXorRollback : assert property (
        @(posedge clk48_i) disable iff (!rstN_i)
        !(commit_i && rollback_i)
    ) else $error("Commit and rollback in the same cycle");

    // Readers must wait for committed data
    aNoEmptyPop : assert property (
        @(posedge clk48_i) disable iff (!rstN_i)
        pop_i |-> committedCount_o != '0
    ) else $error("Pop with no committed byte");

endmodule

`default_nettype wire

//--- src/usbPeTokenDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module usbPeTokenDecoder (
    input  logic              clk48_i,
    input  logic              rstN_i,
    input  usbPePkg::devAddrT devAddr_i,
    input  usbPePkg::rxBeatT  rxByte_i,
    input  logic              byteStrobe_i,
    output usbPePkg::tokenT   token_o,
    output logic              tokenStrobe_o
);

    import usbPePkg::*;

    // Position inside the current packet, saturates at 3
    logic [1:0] byteCnt;
    byteT       pidByte;
    byteT       addrByte;
    logic       pidOk;
    logic       addrOk;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            byteCnt <= 2'd0;
        end else if (byteStrobe_i) begin
            // A last byte always restarts the count, early or not
            if (rxByte_i.isLast) begin
                byteCnt <= 2'd0;
            end else if (byteCnt != 2'd3) begin
                byteCnt <= byteCnt + 2'd1;
            end
        end
    end

    // First two token bytes are kept until the third arrives
    always_ff @(posedge clk48_i) begin
        if (byteStrobe_i && byteCnt == 2'd0) begin
            pidByte <= rxByte_i.data;
        end
        if (byteStrobe_i && byteCnt == 2'd1) begin
            addrByte <= rxByte_i.data;
        end
    end

    // Upper nibble must be the inverse of the lower one
    assign pidOk  = pidByte[7:4] == ~pidByte[3:0];
    assign addrOk = addrByte[6:0] == devAddr_i;

    // Third byte completes the token in its own transfer cycle
    assign tokenStrobe_o = byteStrobe_i && byteCnt == 2'd2;

    assign token_o.pid = pidByte[3:0];
    // Endpoint bit 0 sits in the address byte, bits 3..1 in the last byte
    assign token_o.ep  = {rxByte_i.data[2:0], addrByte[7]};
    // A token longer than three bytes or with a CRC error is not ours
    assign token_o.forMe = pidOk && addrOk && rxByte_i.isLast && rxByte_i.keep;

    // One token per packet, so never two strobes back to back
    aSingleStrobe : assert property (
        @(posedge clk48_i) disable iff (!rstN_i)
        tokenStrobe_o |=> !tokenStrobe_o
    ) else $error("Token strobe held for two cycles");

endmodule

`default_nettype wire

//--- src/usbPePkg.sv
`default_nettype none

package usbPePkg;

    // ============================================================
    // Basic field types
    // ============================================================

    // One byte on the receive or transmit stream
    typedef logic [7:0] byteT;

    // PID without its check nibble
    typedef logic [3:0] pidT;

    // Device address as carried in a token
    typedef logic [6:0] devAddrT;

    // Endpoint number as carried in a token
    typedef logic [3:0] epNumT;

    // PID codes, low nibble of the PID byte
    localparam pidT PID_OUT   = 4'b0001;
    localparam pidT PID_IN    = 4'b1001;
    localparam pidT PID_DATA0 = 4'b0011;
    localparam pidT PID_DATA1 = 4'b1011;
    localparam pidT PID_ACK   = 4'b0010;
    localparam pidT PID_NAK   = 4'b1010;
    localparam pidT PID_STALL = 4'b1110;

    // ============================================================
    // Stream and token records
    // ============================================================

    // Decoded token, forMe only when PID check and address both pass
    typedef struct packed {
        pidT   pid;
        epNumT ep;
        logic  forMe;
    } tokenT;

    // Receive beat from the frontend
    // keep reports the CRC result and is read on the last byte only
    typedef struct packed {
        byteT data;
        logic isLast;
        logic keep;
    } rxBeatT;

    // Transmit beat towards the frontend
    typedef struct packed {
        byteT data;
        logic isLast;
    } txBeatT;

    // Transaction FSM states
    typedef enum logic [2:0] {
        waitToken,
        rxData,
        respond,
        txData
    } peStateT;

endpackage

`default_nettype wire
